//--- alu.sv
`timescale 1ns/1ps

module alu
(
	input alu_pkg::alu_req_t req,
	output logic signed [alu_pkg::DATA_W-1:0] result
);

	// Shift amount, low three bits of b
	logic [2:0] shamt;

	assign shamt = req.b[2:0];

	always_comb
	begin
		case (req.op)
			// Wraps modulo 256 at result width
			alu_pkg::OP_ADD: result = req.a + req.b;
			alu_pkg::OP_SUB: result = req.a - req.b;
			// Bitwise group
			alu_pkg::OP_AND: result = req.a & req.b;
			alu_pkg::OP_OR: result = req.a | req.b;
			alu_pkg::OP_XOR: result = req.a ^ req.b;
			alu_pkg::OP_NOR: result = ~(req.a | req.b);
			// Sign fill
			alu_pkg::OP_SRA: result = req.a >>> shamt;
			// Zero fill
			alu_pkg::OP_SRL: result = $signed($unsigned(req.a) >> shamt);
			// Unknown op code
			default: result = '0;
		endcase
	end

endmodule

//--- alu_pkg.sv
package alu_pkg;

	// Operand and result width
	localparam int DATA_W = 8;

	// Op code, one full byte on the link
	typedef logic [7:0] op_t;

	////////////////////////////////////////////////////////////
	// Operation codes
	////////////////////////////////////////////////////////////

	// Arithmetic
	localparam op_t OP_ADD = 8'h20;
	localparam op_t OP_SUB = 8'h22;

	// Bitwise
	localparam op_t OP_AND = 8'h24;
	localparam op_t OP_OR = 8'h25;
	localparam op_t OP_XOR = 8'h26;
	localparam op_t OP_NOR = 8'h27;

	// Shifts, amount from low bits of b
	localparam op_t OP_SRA = 8'h03;
	localparam op_t OP_SRL = 8'h02;

	// Request as held by the command interface
	typedef struct packed {
		logic signed [DATA_W-1:0] a;
		logic signed [DATA_W-1:0] b;
		op_t op;
	} alu_req_t;

endpackage

//--- byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo
(
	input logic clk,
	input logic reset,
	input logic wr,
	input uart_pkg::byte_t wr_data,
	input logic rd,
	output uart_pkg::byte_t rd_data,
	output logic empty,
	output logic full
);

	uart_pkg::byte_t mem [uart_pkg::FIFO_DEPTH];
	uart_pkg::fifo_ptr_t wr_ptr;
	uart_pkg::fifo_ptr_t rd_ptr;
	uart_pkg::fifo_cnt_t count;
	logic do_wr;
	logic do_rd;

	// Strobes past the flags are ignored
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full = (count == uart_pkg::FIFO_FULL_CNT);

	// Head always visible
	assign rd_data = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap at depth, count tracks occupancy
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Producer and consumer must respect the flags
	assert property (@(posedge clk) disable iff (reset) wr |-> !full);
	assert property (@(posedge clk) disable iff (reset) rd |-> !empty);

endmodule

//--- calc_interface.sv
`timescale 1ns/1ps

module calc_interface
(
	input logic clk,
	input logic reset,
	input logic rx_empty,
	input uart_pkg::byte_t rx_data,
	output logic rx_rd,
	input logic tx_full,
	output logic tx_wr,
	output uart_pkg::byte_t tx_data,
	output alu_pkg::alu_req_t req,
	input logic signed [alu_pkg::DATA_W-1:0] result
);

	typedef enum logic [1:0] {GET_A, GET_B, GET_OP, SEND} calc_state_t;

	calc_state_t state;
	calc_state_t next_state;

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= GET_A;
		else
			state <= next_state;
	end

	// Pop in any GET state once a byte is at the head
	always_comb
	begin
		next_state = state;
		rx_rd = 1'b0;
		tx_wr = 1'b0;
		case (state)
			GET_A,
			GET_B,
			GET_OP:
			begin
				rx_rd = !rx_empty;
				if (!rx_empty)
					next_state = calc_state_t'(state + 2'd1);
			end
			default:
			begin
				// Hold here while tx FIFO is full
				tx_wr = !tx_full;
				if (!tx_full)
					next_state = GET_A;
			end
		endcase
	end

	// Result straight from the ALU
	assign tx_data = uart_pkg::byte_t'(result);

	// Request fields, each loaded by its own pop
	always_ff @(posedge clk)
	begin
		if (rx_rd)
		begin
			case (state)
				GET_A: req.a <= $signed(rx_data);
				GET_B: req.b <= $signed(rx_data);
				GET_OP: req.op <= alu_pkg::op_t'(rx_data);
				default: req <= req;
			endcase
		end
	end

	// One write per command, then back to gathering a
	assert property (@(posedge clk) disable iff (reset)
		tx_wr |-> !tx_full ##1 (state == GET_A && !tx_wr));

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_uart_alu -o sim_tb_uart_alu
./obj_dir/sim_tb_uart_alu

//--- src.f
uart_pkg.sv
alu_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
calc_interface.sv
alu.sv
uart_alu_top.sv
tb_clock.sv
tb_uart_alu.sv

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic clk,
	output logic reset
);

	// 4 ns period, half period 2 ns
	localparam int HALF_PERIOD = 2;
	localparam int RESET_CYCLES = 5;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// Reset over the first five rising edges, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- tb_uart_alu.sv
`timescale 1ns/1ps

module tb_uart_alu;

	// Commands issued over all tests, and worst-case clocks per command
	localparam int COMMAND_COUNT = 34;
	localparam int CMD_CYCLES = 400;
	localparam int QUIET_CYCLES = 200;
	localparam int TIMEOUT_CYCLES = QUIET_CYCLES + COMMAND_COUNT * CMD_CYCLES + 1000;
	localparam int BURST = 5;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	int cycles = 0;
	int seed = 32'hbf8d;

	tb_clock clock_i (.clk(clk), .reset(reset));

	uart_alu_top dut_i (.clk(clk), .reset(reset), .rx(rx), .tx(tx));

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: a result byte never arrived on tx after %0d cycles", cycles);
			$display("Test failed");
			$fatal(1, "watchdog expired");
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////

	// Expected byte straight from the op rules
	function automatic logic [7:0] expected_result(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] op);
		int sum;
		logic [7:0] r;
		r = 8'h00;
		case (op)
			alu_pkg::OP_ADD:
			begin
				sum = (int'(a) + int'(b)) % 256;
				r = sum[7:0];
			end
			alu_pkg::OP_SUB:
			begin
				sum = (int'(a) - int'(b) + 256) % 256;
				r = sum[7:0];
			end
			alu_pkg::OP_AND: r = a & b;
			alu_pkg::OP_OR: r = a | b;
			alu_pkg::OP_XOR: r = a ^ b;
			alu_pkg::OP_NOR: r = ~(a | b);
			alu_pkg::OP_SRA:
			begin
				// One place at a time, sign bit copied in
				r = a;
				for (int k = 0; k < int'(b[2:0]); k++)
					r = {r[7], r[7:1]};
			end
			alu_pkg::OP_SRL:
			begin
				r = a;
				for (int k = 0; k < int'(b[2:0]); k++)
					r = {1'b0, r[7:1]};
			end
			default: r = 8'h00;
		endcase
		return r;
	endfunction

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
		input logic [7:0] a, input logic [7:0] b, input logic [7:0] op);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0t: op %02h a %02h b %02h got %02h expected %02h",
				$time, op, a, b, got, exp);
			$display("Test failed");
			$fatal(1, "result byte differs from reference");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Serial host
	////////////////////////////////////////////////////////////

	// Called on a falling edge, returns on one
	task automatic send_byte(input logic [7:0] value);
		rx = 1'b0;
		repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
		// LSB first
		for (int i = 0; i < 8; i++)
		begin
			rx = value[i];
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
		end
		rx = 1'b1;
		repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
	endtask

	// Samples on falling clock edges near mid-bit
	task automatic recv_byte(output logic [7:0] value);
		@(negedge tx);
		repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk);
		assert (tx === 1'b0)
		else
		begin
			$display("Start bit on tx did not hold low to mid-bit at %0t", $time);
			$display("Test failed");
			$fatal(1, "glitch on tx");
		end
		for (int i = 0; i < 8; i++)
		begin
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
			value[i] = tx;
		end
		repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
		assert (tx === 1'b1)
		else
		begin
			$display("Stop bit on tx was low at %0t, frame is broken", $time);
			$display("Test failed");
			$fatal(1, "framing error on tx");
		end
	endtask

	// One command out, its result back, checked
	task automatic run_command(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op);
		logic [7:0] got;
		logic [7:0] exp;
		exp = expected_result(a, b, op);
		fork
			begin
				send_byte(a);
				send_byte(b);
				send_byte(op);
			end
			recv_byte(got);
		join
		check_byte(got, exp, a, b, op);
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	// Line must stay idle with nothing queued
	task automatic test_idle();
		for (int i = 0; i < QUIET_CYCLES; i++)
		begin
			@(negedge clk);
			assert (tx === 1'b1)
			else
			begin
				$display("Mismatch at %0t: tx is %b while idle, expected 1", $time, tx);
				$display("Test failed");
				$fatal(1, "tx left idle level");
			end
		end
	endtask

	// Signed overflow in both directions
	task automatic test_add_sub();
		run_command(8'd100, 8'd100, alu_pkg::OP_ADD);
		run_command(8'h9c, 8'h9c, alu_pkg::OP_ADD);
		run_command(8'h80, 8'h01, alu_pkg::OP_SUB);
		run_command(8'h05, 8'hf9, alu_pkg::OP_SUB);
	endtask

	task automatic test_bitwise();
		logic [7:0] a;
		logic [7:0] b;
		for (int round = 0; round < 2; round++)
		begin
			a = rand_byte();
			b = rand_byte();
			run_command(a, b, alu_pkg::OP_AND);
			run_command(a, b, alu_pkg::OP_OR);
			run_command(a, b, alu_pkg::OP_XOR);
			run_command(a, b, alu_pkg::OP_NOR);
		end
	endtask

	// Upper bits of b are noise, only the low three count
	task automatic test_shifts();
		logic [7:0] a;
		logic [7:0] b;
		a = rand_byte() | 8'h80;
		for (int k = 0; k < 8; k++)
		begin
			b = rand_byte() & 8'hf8 | 8'(k);
			run_command(a, b, alu_pkg::OP_SRA);
		end
		for (int k = 0; k < 8; k++)
		begin
			b = rand_byte() & 8'hf8 | 8'(k);
			run_command(a, b, alu_pkg::OP_SRL);
		end
		// Undefined op code
		run_command(a, 8'h11, 8'h55);
	endtask

	// Frames with no idle gap, results checked as they come back
	task automatic test_back_to_back();
		logic [7:0] a_q [BURST];
		logic [7:0] b_q [BURST];
		logic [7:0] op_q [BURST];
		logic [7:0] got;
		logic [7:0] ops [4];
		ops[0] = alu_pkg::OP_ADD;
		ops[1] = alu_pkg::OP_SUB;
		ops[2] = alu_pkg::OP_XOR;
		ops[3] = alu_pkg::OP_SRA;
		for (int i = 0; i < BURST; i++)
		begin
			a_q[i] = rand_byte();
			b_q[i] = rand_byte();
			op_q[i] = ops[i % 4];
		end
		fork
			for (int i = 0; i < BURST; i++)
			begin
				send_byte(a_q[i]);
				send_byte(b_q[i]);
				send_byte(op_q[i]);
			end
			for (int j = 0; j < BURST; j++)
			begin
				recv_byte(got);
				check_byte(got, expected_result(a_q[j], b_q[j], op_q[j]),
					a_q[j], b_q[j], op_q[j]);
			end
		join
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rx = 1'b1;
		wait (reset === 1'b0);
		@(negedge clk);
		test_idle();
		test_add_sub();
		test_bitwise();
		test_shifts();
		test_back_to_back();
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- uart_alu_top.sv
`timescale 1ns/1ps

module uart_alu_top
(
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx
);

	// Receive path
	logic rx_push;
	uart_pkg::byte_t rx_byte;
	logic rx_rd;
	logic rx_empty;
	uart_pkg::byte_t rx_head;

	// Transmit path
	logic tx_wr;
	uart_pkg::byte_t tx_byte;
	logic tx_full;
	logic tx_pop;
	logic tx_empty;
	uart_pkg::byte_t tx_head;

	// ALU request and result
	alu_pkg::alu_req_t req;
	logic signed [alu_pkg::DATA_W-1:0] result;

	////////////////////////////////////////////////////////////
	// Serial in, into the rx FIFO
	////////////////////////////////////////////////////////////

	uart_rx uart_rx_i (
		.clk(clk), .reset(reset), .rx(rx), .push(rx_push), .data(rx_byte)
	);

	// No back-pressure to the receiver, full left open
	byte_fifo rx_fifo_i (
		.clk(clk), .reset(reset), .wr(rx_push), .wr_data(rx_byte),
		.rd(rx_rd), .rd_data(rx_head), .empty(rx_empty), .full()
	);

	////////////////////////////////////////////////////////////
	// Command handling
	////////////////////////////////////////////////////////////

	calc_interface calc_interface_i (
		.clk(clk), .reset(reset),
		.rx_empty(rx_empty), .rx_data(rx_head), .rx_rd(rx_rd),
		.tx_full(tx_full), .tx_wr(tx_wr), .tx_data(tx_byte),
		.req(req), .result(result)
	);

	alu alu_i (.req(req), .result(result));

	////////////////////////////////////////////////////////////
	// tx FIFO, serial out
	////////////////////////////////////////////////////////////

	byte_fifo tx_fifo_i (
		.clk(clk), .reset(reset), .wr(tx_wr), .wr_data(tx_byte),
		.rd(tx_pop), .rd_data(tx_head), .empty(tx_empty), .full(tx_full)
	);

	uart_tx uart_tx_i (
		.clk(clk), .reset(reset), .empty(tx_empty), .data(tx_head),
		.pop(tx_pop), .tx(tx)
	);

endmodule

//--- uart_pkg.sv
package uart_pkg;

	////////////////////////////////////////////////////////////
	// Serial link
	////////////////////////////////////////////////////////////

	// One data byte on the line
	typedef logic [7:0] byte_t;

	// Clocks per serial bit, fixed rate
	localparam int CLKS_PER_BIT = 8;

	// Bit-period counter
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// Last clock of a bit period, and the clock at mid-bit
	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_cnt_t BIT_MID = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

	////////////////////////////////////////////////////////////
	// Byte FIFO
	////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = 2;

	// Pointers wrap on their own; count needs one extra bit
	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
	typedef logic [FIFO_AW:0] fifo_cnt_t;
	localparam fifo_cnt_t FIFO_FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx
(
	input logic clk,
	input logic reset,
	input logic rx,
	output logic push,
	output uart_pkg::byte_t data
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic bit_end;
	uart_pkg::bit_cnt_t cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shreg;

	////////////////////////////////////////////////////////////
	// Input synchronizer and edge detect
	////////////////////////////////////////////////////////////

	// Line idles high, so reset to 1
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// High to low on the synced line
	assign start_edge = rx_prev & ~rx_sync;

	// Middle of a data or stop bit
	assign bit_end = (cnt == uart_pkg::BIT_LAST);

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			push <= 1'b0;
		end
		else
		begin
			// Single-cycle strobe
			push <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					if (start_edge)
						state <= RX_START;
				end
				RX_START:
				begin
					// Recheck at mid start bit, a glitch returns to idle
					if (cnt == uart_pkg::BIT_MID)
					begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_STOP:
				begin
					// Bad stop bit drops the frame
					if (bit_end)
					begin
						push <= rx_sync;
						state <= RX_IDLE;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// LSB first, new bit enters at the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bit_end)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == RX_STOP && bit_end && rx_sync)
			data <= shreg;
	end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx
(
	input logic clk,
	input logic reset,
	input logic empty,
	input uart_pkg::byte_t data,
	output logic pop,
	output logic tx
);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t state;
	logic bit_end;
	uart_pkg::bit_cnt_t cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shreg;

	// Take the head byte as soon as the line is free
	assign pop = (state == TX_IDLE) && !empty;

	assign bit_end = (cnt == uart_pkg::BIT_LAST);

	// Line level from state, high while idle or in reset
	always_comb
	begin
		case (state)
			TX_START: tx = 1'b0;
			TX_DATA: tx = shreg[0];
			default: tx = 1'b1;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
		end
		else
		begin
			if (state == TX_IDLE || bit_end)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			case (state)
				TX_IDLE:
					if (pop)
						state <= TX_START;
				TX_START:
					if (bit_end)
					begin
						bit_idx <= '0;
						state <= TX_DATA;
					end
				TX_DATA:
					if (bit_end)
					begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
				default:
					// Stop bit, then free again
					if (bit_end)
						state <= TX_IDLE;
			endcase
		end
	end

	// Payload shifter, LSB leaves first
	always_ff @(posedge clk)
	begin
		if (pop)
			shreg <= data;
		else if (state == TX_DATA && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

	// Pop only with data, and a full start bit follows it
	assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty ##1 !tx [*uart_pkg::CLKS_PER_BIT]);

endmodule
